// ==== flist.f ====
hw/core_track_pkg.sv
hw/busy_scoreboard.sv
hw/fetch_addr_map.sv
hw/perf_counters.sv
hw/core_track_top.sv
test/core_track_assert.sv
test/tb_core_track.sv

// ==== hw/busy_scoreboard.sv ====
`timescale 1ns/1ns
`default_nettype none

module busy_scoreboard #(
    parameter int PRF_NUM  = 64,
    parameter int SB_READS = 2
) (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire                                      flush_i,

    // dispatch side
    input  wire                                      set_busy_0_i,
    input  wire                                      set_busy_1_i,
    input  core_track_pkg::prf_num_t                 set_num_0_i,
    input  core_track_pkg::prf_num_t                 set_num_1_i,

    // writeback side, order is alu0, alu1, lsu, mdu
    input  wire  [3:0]                               clr_en_i,
    input  core_track_pkg::prf_num_t [3:0]           clr_num_i,

    // operand lookups from the issue queue
    input  core_track_pkg::prf_num_t [SB_READS-1:0]  rd_num_l_i,
    input  core_track_pkg::prf_num_t [SB_READS-1:0]  rd_num_r_i,
    output logic [SB_READS-1:0]                      busy_l_o,
    output logic [SB_READS-1:0]                      busy_r_o
);

    logic [PRF_NUM-1:0] busy_q;
    logic [PRF_NUM-1:0] busy_d;

    // clears first so a same-cycle dispatch to that register wins
    always_comb begin
        busy_d = busy_q;
        for (int c = 0; c < 4; c++) begin
            if (clr_en_i[c]) begin
                busy_d[clr_num_i[c]] = 1'b0;
            end
        end
        if (set_busy_0_i) begin
            busy_d[set_num_0_i] = 1'b1;
        end
        if (set_busy_1_i) begin
            busy_d[set_num_1_i] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_d;
        end
    end

    // lookups see the state from the last edge, no bypass of this cycle's updates
    always_comb begin
        for (int r = 0; r < SB_READS; r++) begin
            busy_l_o[r] = busy_q[rd_num_l_i[r]];
            busy_r_o[r] = busy_q[rd_num_r_i[r]];
        end
    end

endmodule

`default_nettype wire

// ==== hw/core_track_pkg.sv ====
`default_nettype none

package core_track_pkg;

    localparam int PRF_NUM = 64;
    localparam int ADDR_W  = 32;
    localparam int CNT_W   = 32;

    typedef logic [5:0] prf_num_t;

    // cycles charged to the redirect counter per redirect
    localparam logic [CNT_W-1:0] REDIRECT_PENALTY = 32'd12;

    // TOTAL_PENALTY must stay last, it is derived and not stored
    typedef enum logic [3:0] {
        FRONT_PAUSE,
        BACK_PAUSE,
        ALU_PAUSE,
        LSU_PAUSE,
        MDU_PAUSE,
        RENAME_PAUSE,
        REDIRECT_PENALTY_CNT,
        BRANCH_CNT,
        REDIRECT_CNT,
        CYCLE_CNT,
        DUAL_COMMIT,
        SINGLE_COMMIT,
        NO_COMMIT,
        TOTAL_PENALTY
    } perf_event_e;

endpackage

`default_nettype wire

// ==== hw/core_track_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_track_top #(
    parameter int PRF_NUM  = core_track_pkg::PRF_NUM,
    parameter int SB_READS = 2
) (
    input  wire                                      clk,
    input  wire                                      rst,

    // dispatch and writeback, shared by all three scoreboards
    input  wire                                      set_busy_0_i,
    input  wire                                      set_busy_1_i,
    input  core_track_pkg::prf_num_t                 set_num_0_i,
    input  core_track_pkg::prf_num_t                 set_num_1_i,
    input  wire  [3:0]                               clr_en_i,
    input  core_track_pkg::prf_num_t [3:0]           clr_num_i,

    input  wire                                      alu_flush_i,
    input  wire                                      lsu_flush_i,
    input  wire                                      mdu_flush_i,

    input  core_track_pkg::prf_num_t [SB_READS-1:0]  alu_rd_num_l_i,
    input  core_track_pkg::prf_num_t [SB_READS-1:0]  alu_rd_num_r_i,
    input  core_track_pkg::prf_num_t [SB_READS-1:0]  lsu_rd_num_l_i,
    input  core_track_pkg::prf_num_t [SB_READS-1:0]  lsu_rd_num_r_i,
    input  core_track_pkg::prf_num_t [SB_READS-1:0]  mdu_rd_num_l_i,
    input  core_track_pkg::prf_num_t [SB_READS-1:0]  mdu_rd_num_r_i,
    output logic [SB_READS-1:0]                      alu_busy_l_o,
    output logic [SB_READS-1:0]                      alu_busy_r_o,
    output logic [SB_READS-1:0]                      lsu_busy_l_o,
    output logic [SB_READS-1:0]                      lsu_busy_r_o,
    output logic [SB_READS-1:0]                      mdu_busy_l_o,
    output logic [SB_READS-1:0]                      mdu_busy_r_o,

    // fetch translation
    input  wire  [core_track_pkg::ADDR_W-1:0]        fetch_va0_i,
    input  wire  [core_track_pkg::ADDR_W-1:0]        fetch_va1_i,
    output logic [core_track_pkg::ADDR_W-1:0]        fetch_pa0_o,
    output logic [core_track_pkg::ADDR_W-1:0]        fetch_pa1_o,

    // perf events
    input  wire                                      icache_pause_i,
    input  wire                                      backend_pause_i,
    input  wire                                      alu_iq_ready_i,
    input  wire                                      lsu_iq_ready_i,
    input  wire                                      mdu_iq_ready_i,
    input  wire                                      rename_alloc_i,
    input  wire                                      redirect_i,
    input  wire                                      branch_i,
    input  wire                                      commit_valid_i,
    input  wire                                      commit_ready_i,
    input  wire                                      inst0_good_i,
    input  wire                                      inst1_good_i,
    input  core_track_pkg::perf_event_e              perf_sel_i,
    output logic [core_track_pkg::CNT_W-1:0]         perf_count_o
);

    busy_scoreboard #(.PRF_NUM(PRF_NUM), .SB_READS(SB_READS)) u_sb_alu (
        .clk(clk), .rst(rst), .flush_i(alu_flush_i),
        .set_busy_0_i(set_busy_0_i), .set_busy_1_i(set_busy_1_i),
        .set_num_0_i(set_num_0_i), .set_num_1_i(set_num_1_i),
        .clr_en_i(clr_en_i), .clr_num_i(clr_num_i),
        .rd_num_l_i(alu_rd_num_l_i), .rd_num_r_i(alu_rd_num_r_i),
        .busy_l_o(alu_busy_l_o), .busy_r_o(alu_busy_r_o)
    );

    busy_scoreboard #(.PRF_NUM(PRF_NUM), .SB_READS(SB_READS)) u_sb_lsu (
        .clk(clk), .rst(rst), .flush_i(lsu_flush_i),
        .set_busy_0_i(set_busy_0_i), .set_busy_1_i(set_busy_1_i),
        .set_num_0_i(set_num_0_i), .set_num_1_i(set_num_1_i),
        .clr_en_i(clr_en_i), .clr_num_i(clr_num_i),
        .rd_num_l_i(lsu_rd_num_l_i), .rd_num_r_i(lsu_rd_num_r_i),
        .busy_l_o(lsu_busy_l_o), .busy_r_o(lsu_busy_r_o)
    );

    busy_scoreboard #(.PRF_NUM(PRF_NUM), .SB_READS(SB_READS)) u_sb_mdu (
        .clk(clk), .rst(rst), .flush_i(mdu_flush_i),
        .set_busy_0_i(set_busy_0_i), .set_busy_1_i(set_busy_1_i),
        .set_num_0_i(set_num_0_i), .set_num_1_i(set_num_1_i),
        .clr_en_i(clr_en_i), .clr_num_i(clr_num_i),
        .rd_num_l_i(mdu_rd_num_l_i), .rd_num_r_i(mdu_rd_num_r_i),
        .busy_l_o(mdu_busy_l_o), .busy_r_o(mdu_busy_r_o)
    );

    // fixed mapping in place of a TLB
    fetch_addr_map u_fetch_addr_map (
        .clk(clk), .rst(rst),
        .va0_i(fetch_va0_i), .va1_i(fetch_va1_i),
        .pa0_o(fetch_pa0_o), .pa1_o(fetch_pa1_o)
    );

    perf_counters u_perf_counters (
        .clk(clk), .rst(rst),
        .icache_pause_i(icache_pause_i), .backend_pause_i(backend_pause_i),
        .alu_iq_ready_i(alu_iq_ready_i), .lsu_iq_ready_i(lsu_iq_ready_i),
        .mdu_iq_ready_i(mdu_iq_ready_i), .rename_alloc_i(rename_alloc_i),
        .redirect_i(redirect_i), .branch_i(branch_i),
        .commit_valid_i(commit_valid_i), .commit_ready_i(commit_ready_i),
        .inst0_good_i(inst0_good_i), .inst1_good_i(inst1_good_i),
        .sel_i(perf_sel_i), .count_o(perf_count_o)
    );

endmodule

`default_nettype wire

// ==== hw/fetch_addr_map.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_addr_map (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire  [core_track_pkg::ADDR_W-1:0]    va0_i,
    input  wire  [core_track_pkg::ADDR_W-1:0]    va1_i,
    output logic [core_track_pkg::ADDR_W-1:0]    pa0_o,
    output logic [core_track_pkg::ADDR_W-1:0]    pa1_o
);

    // kseg0 and kseg1 (0x8000_0000 to 0xbfff_ffff) drop the top three bits,
    // everything else goes through as is
    function automatic logic [core_track_pkg::ADDR_W-1:0] map_va(
        input logic [core_track_pkg::ADDR_W-1:0] va
    );
        logic [core_track_pkg::ADDR_W-1:0] pa;
        pa = va;
        if (va[31:30] == 2'b10) begin
            pa[31:29] = 3'b000;
        end
        return pa;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            pa0_o <= '0;
            pa1_o <= '0;
        end else begin
            pa0_o <= map_va(va0_i);
            pa1_o <= map_va(va1_i);
        end
    end

endmodule

`default_nettype wire

// ==== hw/perf_counters.sv ====
`timescale 1ns/1ns
`default_nettype none

module perf_counters (
    input  wire                                 clk,
    input  wire                                 rst,

    // pause levels
    input  wire                                 icache_pause_i,
    input  wire                                 backend_pause_i,
    input  wire                                 alu_iq_ready_i,
    input  wire                                 lsu_iq_ready_i,
    input  wire                                 mdu_iq_ready_i,
    input  wire                                 rename_alloc_i,

    input  wire                                 redirect_i,
    input  wire                                 branch_i,

    // commit stage
    input  wire                                 commit_valid_i,
    input  wire                                 commit_ready_i,
    input  wire                                 inst0_good_i,
    input  wire                                 inst1_good_i,

    input  core_track_pkg::perf_event_e         sel_i,
    output logic [core_track_pkg::CNT_W-1:0]    count_o
);

    // every member before TOTAL_PENALTY has its own register
    localparam int N_CNT = int'(core_track_pkg::TOTAL_PENALTY);

    logic [core_track_pkg::CNT_W-1:0] cnt_q [N_CNT];
    logic [N_CNT-1:0]                 ev;
    logic [core_track_pkg::CNT_W-1:0] total_penalty;
    logic                             dual_commit;
    logic                             single_commit;

    assign dual_commit   = commit_valid_i && commit_ready_i && inst0_good_i && inst1_good_i;
    assign single_commit = commit_valid_i && commit_ready_i && !dual_commit;

    assign ev[core_track_pkg::FRONT_PAUSE]          = icache_pause_i;
    assign ev[core_track_pkg::BACK_PAUSE]           = backend_pause_i;
    assign ev[core_track_pkg::ALU_PAUSE]            = !alu_iq_ready_i;
    assign ev[core_track_pkg::LSU_PAUSE]            = !lsu_iq_ready_i;
    assign ev[core_track_pkg::MDU_PAUSE]            = !mdu_iq_ready_i;
    assign ev[core_track_pkg::RENAME_PAUSE]         = !rename_alloc_i;
    assign ev[core_track_pkg::REDIRECT_PENALTY_CNT] = redirect_i;
    assign ev[core_track_pkg::BRANCH_CNT]           = branch_i;
    assign ev[core_track_pkg::REDIRECT_CNT]         = redirect_i;
    assign ev[core_track_pkg::CYCLE_CNT]            = 1'b1;
    assign ev[core_track_pkg::DUAL_COMMIT]          = dual_commit;
    assign ev[core_track_pkg::SINGLE_COMMIT]        = single_commit;
    assign ev[core_track_pkg::NO_COMMIT]            = !dual_commit && !single_commit;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < N_CNT; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N_CNT; i++) begin
                if (ev[i]) begin
                    // the redirect penalty counter is charged a fixed cost per redirect
                    if (i == int'(core_track_pkg::REDIRECT_PENALTY_CNT)) begin
                        cnt_q[i] <= cnt_q[i] + core_track_pkg::REDIRECT_PENALTY;
                    end else begin
                        cnt_q[i] <= cnt_q[i] + 1'b1;
                    end
                end
            end
        end
    end

    assign total_penalty = cnt_q[core_track_pkg::FRONT_PAUSE]
                         + cnt_q[core_track_pkg::BACK_PAUSE]
                         + cnt_q[core_track_pkg::REDIRECT_PENALTY_CNT];

    // unused select codes read as zero
    always_comb begin
        if (sel_i == core_track_pkg::TOTAL_PENALTY) begin
            count_o = total_penalty;
        end else if (int'(sel_i) < N_CNT) begin
            count_o = cnt_q[sel_i];
        end else begin
            count_o = '0;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile and run with Verilator; exit status reports pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module tb_core_track \
    -f flist.f \
    -o sim_core_track &&
./obj_dir/sim_core_track || exit 1

// ==== test/core_track_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_track_assert #(
    parameter int SB_READS = 2
) (
    input wire                clk,
    input wire                rst,
    input wire                alu_flush_i,
    input wire                lsu_flush_i,
    input wire                mdu_flush_i,
    input wire [SB_READS-1:0] alu_busy_l_o,
    input wire [SB_READS-1:0] alu_busy_r_o,
    input wire [SB_READS-1:0] lsu_busy_l_o,
    input wire [SB_READS-1:0] lsu_busy_r_o,
    input wire [SB_READS-1:0] mdu_busy_l_o,
    input wire [SB_READS-1:0] mdu_busy_r_o,
    input wire [31:0]         fetch_va0_i,
    input wire [31:0]         fetch_va1_i,
    input wire [31:0]         fetch_pa0_o,
    input wire [31:0]         fetch_pa1_o,
    input wire [31:0]         perf_count_o
);

    function automatic logic [31:0] unmapped_pa(input logic [31:0] va);
        if (va >= 32'h8000_0000 && va <= 32'hbfff_ffff) return {3'b000, va[28:0]};
        return va;
    endfunction

    pa0_follows_va0: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> fetch_pa0_o == unmapped_pa($past(fetch_va0_i)))
        else $error("fetch_pa0_o is not the mapped address of the previous cycle");

    pa1_follows_va1: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> fetch_pa1_o == unmapped_pa($past(fetch_va1_i)))
        else $error("fetch_pa1_o is not the mapped address of the previous cycle");

    alu_flush_clears: assert property (@(posedge clk)
        alu_flush_i |=> (alu_busy_l_o == '0 && alu_busy_r_o == '0))
        else $error("alu scoreboard reports busy after a flush");

    lsu_flush_clears: assert property (@(posedge clk)
        lsu_flush_i |=> (lsu_busy_l_o == '0 && lsu_busy_r_o == '0))
        else $error("lsu scoreboard reports busy after a flush");

    mdu_flush_clears: assert property (@(posedge clk)
        mdu_flush_i |=> (mdu_busy_l_o == '0 && mdu_busy_r_o == '0))
        else $error("mdu scoreboard reports busy after a flush");

    count_zero_after_reset: assert property (@(posedge clk)
        rst |=> perf_count_o == '0)
        else $error("perf counter is not zero after reset");

endmodule

bind core_track_top core_track_assert #(.SB_READS(SB_READS)) u_core_track_assert (
    .clk(clk), .rst(rst),
    .alu_flush_i(alu_flush_i), .lsu_flush_i(lsu_flush_i), .mdu_flush_i(mdu_flush_i),
    .alu_busy_l_o(alu_busy_l_o), .alu_busy_r_o(alu_busy_r_o),
    .lsu_busy_l_o(lsu_busy_l_o), .lsu_busy_r_o(lsu_busy_r_o),
    .mdu_busy_l_o(mdu_busy_l_o), .mdu_busy_r_o(mdu_busy_r_o),
    .fetch_va0_i(fetch_va0_i), .fetch_va1_i(fetch_va1_i),
    .fetch_pa0_o(fetch_pa0_o), .fetch_pa1_o(fetch_pa1_o),
    .perf_count_o(perf_count_o)
);

`default_nettype wire

// ==== test/tb_core_track.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_core_track;

    localparam int SB_READS     = 2;
    localparam int RESET_CYCLES = 10;
    localparam int TEST_CYCLES  = 400;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + TEST_CYCLES) * 8 * 2;

    logic                                     clk = 1'b0;
    logic                                     rst;
    logic                                     set_busy_0;
    logic                                     set_busy_1;
    core_track_pkg::prf_num_t                 set_num_0;
    core_track_pkg::prf_num_t                 set_num_1;
    logic [3:0]                               clr_en;
    core_track_pkg::prf_num_t [3:0]           clr_num;
    logic [2:0]                               flush;
    core_track_pkg::prf_num_t [SB_READS-1:0]  rd_l [3];
    core_track_pkg::prf_num_t [SB_READS-1:0]  rd_r [3];
    logic [SB_READS-1:0]                      busy_l [3];
    logic [SB_READS-1:0]                      busy_r [3];
    logic [31:0]                              va0;
    logic [31:0]                              va1;
    logic [31:0]                              pa0;
    logic [31:0]                              pa1;
    logic                                     icache_pause;
    logic                                     backend_pause;
    logic                                     alu_rdy;
    logic                                     lsu_rdy;
    logic                                     mdu_rdy;
    logic                                     rename_alloc;
    logic                                     redirect;
    logic                                     branch;
    logic                                     cvalid;
    logic                                     cready;
    logic                                     good0;
    logic                                     good1;
    core_track_pkg::perf_event_e              sel;
    logic [31:0]                              count;

    // reference model state
    logic [63:0] sb_m [3];
    logic [31:0] pa_m0;
    logic [31:0] pa_m1;
    logic [31:0] cnt_m [13];

    core_track_top #(.SB_READS(SB_READS)) u_core_track_top (
        .clk(clk), .rst(rst),
        .set_busy_0_i(set_busy_0), .set_busy_1_i(set_busy_1),
        .set_num_0_i(set_num_0), .set_num_1_i(set_num_1),
        .clr_en_i(clr_en), .clr_num_i(clr_num),
        .alu_flush_i(flush[0]), .lsu_flush_i(flush[1]), .mdu_flush_i(flush[2]),
        .alu_rd_num_l_i(rd_l[0]), .alu_rd_num_r_i(rd_r[0]),
        .lsu_rd_num_l_i(rd_l[1]), .lsu_rd_num_r_i(rd_r[1]),
        .mdu_rd_num_l_i(rd_l[2]), .mdu_rd_num_r_i(rd_r[2]),
        .alu_busy_l_o(busy_l[0]), .alu_busy_r_o(busy_r[0]),
        .lsu_busy_l_o(busy_l[1]), .lsu_busy_r_o(busy_r[1]),
        .mdu_busy_l_o(busy_l[2]), .mdu_busy_r_o(busy_r[2]),
        .fetch_va0_i(va0), .fetch_va1_i(va1), .fetch_pa0_o(pa0), .fetch_pa1_o(pa1),
        .icache_pause_i(icache_pause), .backend_pause_i(backend_pause),
        .alu_iq_ready_i(alu_rdy), .lsu_iq_ready_i(lsu_rdy), .mdu_iq_ready_i(mdu_rdy),
        .rename_alloc_i(rename_alloc), .redirect_i(redirect), .branch_i(branch),
        .commit_valid_i(cvalid), .commit_ready_i(cready),
        .inst0_good_i(good0), .inst1_good_i(good1),
        .perf_sel_i(sel), .perf_count_o(count)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] expected_pa(input logic [31:0] va);
        if (va >= 32'h8000_0000 && va <= 32'hbfff_ffff) begin
            return va & 32'h1fff_ffff;
        end
        return va;
    endfunction

    function automatic logic [31:0] expected_count(input core_track_pkg::perf_event_e s);
        if (s == core_track_pkg::TOTAL_PENALTY) begin
            return cnt_m[core_track_pkg::FRONT_PAUSE] + cnt_m[core_track_pkg::BACK_PAUSE]
                 + cnt_m[core_track_pkg::REDIRECT_PENALTY_CNT];
        end
        return cnt_m[s];
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic bump(input core_track_pkg::perf_event_e e, input logic hit);
        if (hit) begin
            cnt_m[e] = cnt_m[e] + ((e == core_track_pkg::REDIRECT_PENALTY_CNT) ? 32'd12 : 32'd1);
        end
    endtask

    // model follows the inputs that were stable at this edge
    always @(posedge clk) begin
        logic dual;
        logic single;
        dual   = cvalid && cready && good0 && good1;
        single = cvalid && cready && !dual;
        if (rst) begin
            for (int q = 0; q < 3; q++) sb_m[q] = '0;
            for (int i = 0; i < 13; i++) cnt_m[i] = '0;
            pa_m0 = '0;
            pa_m1 = '0;
        end else begin
            for (int q = 0; q < 3; q++) begin
                if (flush[q]) begin
                    sb_m[q] = '0;
                end else begin
                    for (int c = 0; c < 4; c++) begin
                        if (clr_en[c]) sb_m[q][clr_num[c]] = 1'b0;
                    end
                    if (set_busy_0) sb_m[q][set_num_0] = 1'b1;
                    if (set_busy_1) sb_m[q][set_num_1] = 1'b1;
                end
            end
            pa_m0 = expected_pa(va0);
            pa_m1 = expected_pa(va1);
            bump(core_track_pkg::FRONT_PAUSE, icache_pause);
            bump(core_track_pkg::BACK_PAUSE, backend_pause);
            bump(core_track_pkg::ALU_PAUSE, !alu_rdy);
            bump(core_track_pkg::LSU_PAUSE, !lsu_rdy);
            bump(core_track_pkg::MDU_PAUSE, !mdu_rdy);
            bump(core_track_pkg::RENAME_PAUSE, !rename_alloc);
            bump(core_track_pkg::REDIRECT_PENALTY_CNT, redirect);
            bump(core_track_pkg::BRANCH_CNT, branch);
            bump(core_track_pkg::REDIRECT_CNT, redirect);
            bump(core_track_pkg::CYCLE_CNT, 1'b1);
            bump(core_track_pkg::DUAL_COMMIT, dual);
            bump(core_track_pkg::SINGLE_COMMIT, single);
            bump(core_track_pkg::NO_COMMIT, !dual && !single);
        end
    end

    // outputs are settled mid-cycle
    always @(negedge clk) begin
        for (int q = 0; q < 3; q++) begin
            for (int r = 0; r < SB_READS; r++) begin
                check($sformatf("busy_l[%0d][%0d]", q, r), 32'(busy_l[q][r]),
                      32'(sb_m[q][rd_l[q][r]]));
                check($sformatf("busy_r[%0d][%0d]", q, r), 32'(busy_r[q][r]),
                      32'(sb_m[q][rd_r[q][r]]));
            end
        end
        check("fetch_pa0_o", pa0, pa_m0);
        check("fetch_pa1_o", pa1, pa_m1);
        check("perf_count_o", count, expected_count(sel));
    end

    task automatic idle_inputs();
        set_busy_0 = 1'b0;
        set_busy_1 = 1'b0;
        clr_en     = '0;
        flush      = '0;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] pick_va();
        logic [31:0] edges [6];
        edges = '{32'h0, 32'h7fff_ffff, 32'h8000_0000, 32'hbfff_ffff, 32'hc000_0000,
                  32'hffff_ffff};
        if ($urandom % 4 == 0) return edges[$urandom % 6];
        return $urandom;
    endfunction

    task automatic random_inputs();
        logic [31:0] r;
        r          = $urandom;
        set_busy_0 = r[0];
        set_busy_1 = r[1];
        set_num_0  = 6'($urandom);
        set_num_1  = 6'($urandom);
        clr_en     = r[5:2];
        for (int c = 0; c < 4; c++) clr_num[c] = 6'($urandom);
        // occasional set and clear of one register in the same cycle
        if (r[6]) clr_num[0] = set_num_0;
        flush = {r[10:8] == 3'd0, r[13:11] == 3'd0, r[16:14] == 3'd0};
        for (int q = 0; q < 3; q++) begin
            for (int i = 0; i < SB_READS; i++) begin
                rd_l[q][i] = 6'($urandom);
                rd_r[q][i] = 6'($urandom);
            end
        end
        va0 = pick_va();
        va1 = pick_va();
        r   = $urandom;
        {icache_pause, backend_pause, alu_rdy, lsu_rdy, mdu_rdy, rename_alloc} = r[5:0];
        {redirect, branch, cvalid, cready, good0, good1} = r[11:6];
        sel = core_track_pkg::perf_event_e'(4'($urandom % 14));
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the test did not finish in %0d ns", TIMEOUT_NS);
        $display("sim failed");
        $fatal(1);
    end

    initial begin
        logic [31:0] n_dual;
        logic [31:0] n_single;
        logic [31:0] n_none;
        logic [31:0] n_cycle;
        void'($urandom(58));
        for (int q = 0; q < 3; q++) sb_m[q] = '0;
        for (int i = 0; i < 13; i++) cnt_m[i] = '0;
        pa_m0 = '0;
        pa_m1 = '0;
        rst = 1'b1;
        idle_inputs();
        set_num_0 = '0;
        set_num_1 = '0;
        clr_num   = '0;
        for (int q = 0; q < 3; q++) begin
            rd_l[q] = '0;
            rd_r[q] = '0;
        end
        va0 = '0;
        va1 = '0;
        {icache_pause, backend_pause, redirect, branch} = '0;
        {alu_rdy, lsu_rdy, mdu_rdy, rename_alloc} = '1;
        {cvalid, cready, good0, good1} = '0;
        sel = core_track_pkg::FRONT_PAUSE;
        repeat (RESET_CYCLES) next_cycle();
        rst = 1'b0;

        // set through both dispatch ports, then look them up everywhere
        set_busy_0 = 1'b1;
        set_num_0  = 6'd5;
        set_busy_1 = 1'b1;
        set_num_1  = 6'd9;
        next_cycle();
        idle_inputs();
        for (int q = 0; q < 3; q++) begin
            rd_l[q] = {6'd9, 6'd5};
            rd_r[q] = {6'd12, 6'd9};
        end
        next_cycle();
        // set wins over a clear of the same register
        set_busy_0 = 1'b1;
        set_num_0  = 6'd12;
        clr_en     = 4'b0010;
        clr_num[1] = 6'd12;
        next_cycle();
        idle_inputs();
        clr_en     = 4'b0100;
        clr_num[2] = 6'd5;
        next_cycle();
        idle_inputs();
        flush[0] = 1'b1;
        next_cycle();
        idle_inputs();
        repeat (2) next_cycle();

        repeat (300) begin
            random_inputs();
            next_cycle();
        end

        // commit classes must cover every cycle exactly once
        // no commits from here on so each later cycle counts as no-commit
        idle_inputs();
        {cvalid, cready, good0, good1} = '0;
        sel = core_track_pkg::DUAL_COMMIT;
        @(negedge clk);
        n_dual = count;
        sel = core_track_pkg::SINGLE_COMMIT;
        @(negedge clk);
        n_single = count;
        sel = core_track_pkg::NO_COMMIT;
        @(negedge clk);
        n_none = count;
        sel = core_track_pkg::CYCLE_CNT;
        @(negedge clk);
        // the cycle count holds one idle cycle more than the no-commit read
        n_cycle = count - 32'd1;
        check("commit class sum", n_dual + n_single + n_none, n_cycle);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
